//--- design/synth_ctrl_pkg.sv
package synth_ctrl_pkg;

	typedef logic [7:0] param_word_t; // one stored parameter byte

	typedef struct packed {
		logic [7:0]  num;  // controller number
		param_word_t data; // controller value
	} midi_cc_t;

	typedef struct packed {
		logic [7:0]  idx; // slider index on the touch panel
		param_word_t val;
	} touch_ev_t;

	// cpu address layout, column in the low nibble
	typedef struct packed {
		logic [4:0] slot; // bank*V_OSC + row, or common slots
		logic       half; // column bit 3
		logic [2:0] col;  // column low bits
	} store_addr_t;

	typedef struct packed {
		logic        en;
		store_addr_t addr;
		param_word_t data;
	} store_wr_t;

	// cc numbers of the controller surface
	localparam logic [7:0] CC_BTN_UP_LO = 8'd22;
	localparam logic [7:0] CC_BTN_UP_HI = 8'd29;
	localparam logic [7:0] CC_MASTER    = 8'd39;
	localparam logic [7:0] CC_FADER_LO  = 8'd48;
	localparam logic [7:0] CC_FADER_HI  = 8'd55;
	localparam logic [7:0] CC_BTN_LO_LO = 8'd56;
	localparam logic [7:0] CC_BTN_LO_HI = 8'd63;
	localparam logic [7:0] CC_KNOB_LO   = 8'd76;
	localparam logic [7:0] CC_KNOB_HI   = 8'd83;

	// touch index ranges, exclusive upper ends
	localparam logic [7:0] TOUCH_ENV_END = 8'd32;
	localparam logic [7:0] TOUCH_OSC_END = 8'd92;
	localparam logic [7:0] TOUCH_COM_END = 8'd94;

	localparam logic [13:0] PITCH_CENTER = 14'd8191; // bend wheel at rest
	localparam logic [3:0]  EDIT_ROW_COL = 4'd4;     // common slot column of edit row

	// power-up contents of one store byte
	function automatic param_word_t default_value(input logic [3:0] col,
		input logic [4:0] slot, input int v_osc);
		param_word_t val;
		val = 8'h00;
		if (int'(slot) < v_osc) begin // envelope bank
			if (col == 4'd6)
				val = 8'h7f;
		end else if (int'(slot) < 2 * v_osc) begin // osc bank
			if (col inside {4'd0, 4'd1, 4'd8, 4'd9})
				val = 8'h40; // centred
			else if (col == 4'd2)
				val = 8'h7f;
		end else if (int'(slot) == 4 * v_osc) begin
			if (col == 4'd0)
				val = 8'h02;
			else if (col == 4'd1)
				val = 8'd60; // master volume
		end
		return val;
	endfunction

endpackage

//--- design/strobe_capture.sv
`timescale 1ns/1ps

// one-deep event holder for a strobe plus its payload
module strobe_capture #(
	parameter type payload_t = logic [15:0]
) (
	input  logic     CLOCK_25,
	input  logic     ctrl_cmd_r,
	input  logic     strobe,
	input  payload_t payload,
	input  logic     accept,
	output logic     pending,
	output payload_t held
);

	logic     strb_s1, strb_s2; // two-flop sync
	payload_t pay_s1;           // payload sampled alongside strobe
	logic     rise;

	assign rise = strb_s1 & ~strb_s2;

	always_ff @(posedge CLOCK_25 or posedge ctrl_cmd_r) begin
		if (ctrl_cmd_r) begin
			strb_s1 <= 1'b0;
			strb_s2 <= 1'b0;
			pending <= 1'b0;
		end else begin
			strb_s1 <= strobe;
			strb_s2 <= strb_s1;
			if (rise)
				pending <= 1'b1; // new edge wins over accept
			else if (accept)
				pending <= 1'b0;
		end
	end

	// payload path, no reset
	always_ff @(posedge CLOCK_25) begin
		pay_s1 <= payload;
		if (rise)
			held <= pay_s1; // last edge overwrites
	end

endmodule

//--- design/ctrl_map.sv
`timescale 1ns/1ps

// cc / touch event to store address and byte
module ctrl_map #(
	parameter  int V_OSC   = 4,
	localparam int O_WIDTH = (V_OSC > 1) ? $clog2(V_OSC) : 1
) (
	input  logic                      CLOCK_25,
	input  logic                      ctrl_cmd_r,
	input  synth_ctrl_pkg::midi_cc_t  cc,
	input  synth_ctrl_pkg::touch_ev_t touch,
	input  logic                      use_touch,
	input  logic                      take,
	input  logic [O_WIDTH-1:0]        edit_row,
	output synth_ctrl_pkg::store_wr_t wr
);

	localparam int COM_SLOT = 4 * V_OSC; // bank 4, bank 5 follows

	logic                       half_lat; // selects columns 8-15 for faders and knobs
	logic                       en;
	logic [2:0]                 bank;
	logic [O_WIDTH-1:0]         row;
	logic [2:0]                 col_lo;
	logic                       half;
	synth_ctrl_pkg::param_word_t data;
	logic                       up_btn;

	assign up_btn = (cc.num >= synth_ctrl_pkg::CC_BTN_UP_LO) &&
		(cc.num <= synth_ctrl_pkg::CC_BTN_UP_HI);

	always_ff @(posedge CLOCK_25 or posedge ctrl_cmd_r) begin
		if (ctrl_cmd_r)
			half_lat <= 1'b0;
		else if (take && !use_touch && up_btn)
			half_lat <= cc.data[0]; // odd data -> upper half
	end

	always_comb begin
		en     = 1'b0;
		bank   = 3'd0;
		row    = '0;
		col_lo = 3'd0;
		half   = 1'b0;
		data   = cc.data;
		if (use_touch) begin
			data = touch.val;
			if (touch.idx < synth_ctrl_pkg::TOUCH_ENV_END) begin // envelope sliders
				en     = 1'b1;
				row    = O_WIDTH'(touch.idx[4:3]);
				col_lo = {touch.idx[0], touch.idx[2], touch.idx[1]}; // panel order
			end else if (touch.idx < synth_ctrl_pkg::TOUCH_OSC_END) begin
				en     = 1'b1;
				bank   = 3'd1;
				row    = O_WIDTH'({touch.idx[6], touch.idx[4]});
				col_lo = touch.idx[2:0];
				half   = touch.idx[3];
			end else if (touch.idx < synth_ctrl_pkg::TOUCH_COM_END) begin
				en     = 1'b1;
				bank   = 3'd4;
				col_lo = 3'(touch.idx - synth_ctrl_pkg::TOUCH_OSC_END);
			end
		end else if (up_btn) begin
			en     = 1'b1;
			bank   = 3'd5;
			col_lo = 3'd6;
			data   = cc.num - synth_ctrl_pkg::CC_BTN_UP_LO; // button index
		end else if (cc.num == synth_ctrl_pkg::CC_MASTER) begin
			en     = 1'b1;
			bank   = 3'd4;
			col_lo = 3'd1;
		end else if (cc.num >= synth_ctrl_pkg::CC_FADER_LO &&
			cc.num <= synth_ctrl_pkg::CC_FADER_HI) begin
			en     = 1'b1;
			row    = edit_row;
			col_lo = 3'(cc.num - synth_ctrl_pkg::CC_FADER_LO);
			half   = half_lat;
		end else if (cc.num >= synth_ctrl_pkg::CC_BTN_LO_LO &&
			cc.num <= synth_ctrl_pkg::CC_BTN_LO_HI) begin
			en     = 1'b1; // picks the edit row
			bank   = 3'd4;
			col_lo = synth_ctrl_pkg::EDIT_ROW_COL[2:0];
			data   = cc.num - synth_ctrl_pkg::CC_BTN_LO_LO;
		end else if (cc.num >= synth_ctrl_pkg::CC_KNOB_LO &&
			cc.num <= synth_ctrl_pkg::CC_KNOB_HI) begin
			en     = 1'b1;
			bank   = 3'd1;
			row    = edit_row;
			col_lo = 3'(cc.num - synth_ctrl_pkg::CC_KNOB_LO);
			half   = half_lat;
		end
	end

	always_comb begin
		wr.en        = en;
		wr.addr.half = half;
		wr.addr.col  = col_lo;
		wr.data      = data;
		if (bank >= 3'd4)
			wr.addr.slot = 5'(COM_SLOT + int'(bank) - 4); // row ignored
		else
			wr.addr.slot = 5'(int'(bank) * V_OSC + int'(row));
	end

endmodule

//--- design/init_counter.sv
`timescale 1ns/1ps

// walks all store addresses once after reset
module init_counter #(
	parameter int V_OSC = 4
) (
	input  logic                        CLOCK_25,
	input  logic                        ctrl_cmd_r,
	input  logic                        start,
	output synth_ctrl_pkg::store_addr_t addr,
	output logic                        done
);

	localparam int SLOTS = 4 * V_OSC + 2;

	logic [4:0] slot_cnt;
	logic [3:0] col_cnt; // inner loop, 16 columns
	logic       last;

	assign last = (slot_cnt == 5'(SLOTS - 1)) && (col_cnt == 4'hf);

	always_ff @(posedge CLOCK_25 or posedge ctrl_cmd_r) begin
		if (ctrl_cmd_r) begin
			slot_cnt <= 5'd0;
			col_cnt  <= 4'd0;
			done     <= 1'b0;
		end else if (start && !done) begin
			col_cnt <= col_cnt + 4'd1; // wraps into next slot
			if (col_cnt == 4'hf)
				slot_cnt <= slot_cnt + 5'd1;
			if (last)
				done <= 1'b1; // sticks until reset
		end
	end

	assign addr.slot = slot_cnt;
	assign addr.half = col_cnt[3];
	assign addr.col  = col_cnt[2:0];

endmodule

//--- design/write_sequencer.sv
`timescale 1ns/1ps

// arbitrates init, cc, touch and cpu read onto the store
module write_sequencer #(
	parameter int V_OSC = 4
) (
	input  logic                        CLOCK_25,
	input  logic                        ctrl_cmd_r,
	input  logic                        cc_pending,
	input  logic                        touch_pending,
	input  logic                        rd_pending,
	input  synth_ctrl_pkg::store_addr_t init_addr,
	input  logic                        init_done,
	input  synth_ctrl_pkg::store_wr_t   map_wr,
	input  synth_ctrl_pkg::store_addr_t rd_adr,
	output logic                        init_start,
	output logic                        cc_accept,
	output logic                        touch_accept,
	output logic                        rd_accept,
	output logic                        use_touch,
	output logic                        take,
	output synth_ctrl_pkg::store_wr_t   wr,
	output synth_ctrl_pkg::store_addr_t store_rd_adr,
	output logic                        rd_en,
	output logic                        busy
);

	typedef enum logic [1:0] {INIT, IDLE, WRITE, READ} seq_state_t;

	seq_state_t                  state;
	logic                        src_touch; // source served in WRITE
	logic                        go_rd;
	synth_ctrl_pkg::store_addr_t rd_adr_q;

	// read only when no write source waits
	assign go_rd = (state == IDLE) && !cc_pending && !touch_pending && rd_pending;

	always_ff @(posedge CLOCK_25 or posedge ctrl_cmd_r) begin
		if (ctrl_cmd_r) begin
			state     <= INIT;
			src_touch <= 1'b0;
		end else begin
			case (state)
				INIT: if (init_done) state <= IDLE;
				IDLE: begin
					if (cc_pending) begin // cc first
						src_touch <= 1'b0;
						state     <= WRITE;
					end else if (touch_pending) begin
						src_touch <= 1'b1;
						state     <= WRITE;
					end else if (rd_pending) begin
						state <= READ;
					end
				end
				default: state <= IDLE; // WRITE and READ take one cycle
			endcase
		end
	end

	always_ff @(posedge CLOCK_25) begin
		if (go_rd)
			rd_adr_q <= rd_adr; // freeze the cpu address
	end

	assign init_start   = (state == INIT);
	assign busy         = (state == INIT);
	assign take         = (state == WRITE);
	assign use_touch    = src_touch;
	assign cc_accept    = take & ~src_touch;
	assign touch_accept = take & src_touch;
	assign rd_accept    = go_rd;
	assign rd_en        = (state == READ);
	assign store_rd_adr = rd_adr_q;

	always_comb begin
		wr = '0;
		case (state)
			INIT: begin
				wr.en   = ~init_done;
				wr.addr = init_addr;
				wr.data = synth_ctrl_pkg::default_value({init_addr.half, init_addr.col},
					init_addr.slot, V_OSC);
			end
			WRITE:   wr = map_wr; // en low for unmapped numbers
			default: wr = '0;
		endcase
	end

endmodule

//--- design/param_store.sv
`timescale 1ns/1ps

// parameter ram, 16 columns by 4*V_OSC+2 slots
module param_store #(
	parameter  int V_OSC   = 4,
	localparam int O_WIDTH = (V_OSC > 1) ? $clog2(V_OSC) : 1
) (
	input  logic                        CLOCK_25,
	input  logic                        ctrl_cmd_r,
	input  synth_ctrl_pkg::store_wr_t   wr,
	input  logic                        rd_en,
	input  synth_ctrl_pkg::store_addr_t rd_adr,
	output synth_ctrl_pkg::param_word_t rd_data,
	output logic [O_WIDTH-1:0]          edit_row
);

	localparam int SLOTS    = 4 * V_OSC + 2;
	localparam int DEPTH    = 16 * SLOTS;
	localparam int COM_SLOT = 4 * V_OSC;

	synth_ctrl_pkg::param_word_t mem [DEPTH]; // slot*16 + column

	logic [8:0] wr_idx, rd_idx;
	logic       edit_hit;

	assign wr_idx = wr.addr; // packed layout is already slot*16 + column
	assign rd_idx = rd_adr;

	assign edit_hit = wr.en && (wr.addr.slot == 5'(COM_SLOT)) &&
		({wr.addr.half, wr.addr.col} == synth_ctrl_pkg::EDIT_ROW_COL);

	always_ff @(posedge CLOCK_25) begin
		if (wr.en && (int'(wr_idx) < DEPTH))
			mem[wr_idx] <= wr.data;
	end

	always_ff @(posedge CLOCK_25 or posedge ctrl_cmd_r) begin
		if (ctrl_cmd_r) begin
			rd_data  <= '0;
			edit_row <= '0;
		end else begin
			if (rd_en) begin
				if (int'(rd_idx) < DEPTH)
					rd_data <= mem[rd_idx];
				else
					rd_data <= '0; // past last slot
			end
			if (edit_hit)
				edit_row <= wr.data[O_WIDTH-1:0]; // mirror of the row select
		end
	end

endmodule

//--- design/synth_ctrl_top.sv
`timescale 1ns/1ps

// controller parameter unit, cc / touch / cpu read / pitch bend
module synth_ctrl_top #(
	parameter  int V_OSC   = 4,
	localparam int O_WIDTH = (V_OSC > 1) ? $clog2(V_OSC) : 1
) (
	input  logic                        CLOCK_25,
	input  logic                        ctrl_cmd_r,
	input  logic                        cc_strobe,
	input  synth_ctrl_pkg::midi_cc_t    cc_in,
	input  logic                        touch_strobe,
	input  synth_ctrl_pkg::touch_ev_t   touch_in,
	input  logic                        pitch_strobe,
	input  synth_ctrl_pkg::midi_cc_t    pitch_in,
	input  logic                        cpu_rd,
	input  synth_ctrl_pkg::store_addr_t cpu_adr,
	output synth_ctrl_pkg::param_word_t cpu_rd_data,
	output logic [O_WIDTH-1:0]          edit_row,
	output logic [13:0]                 pitch_val,
	output logic                        busy
);

	logic                        cc_pending, touch_pending, rd_pending;
	logic                        cc_accept, touch_accept, rd_accept;
	synth_ctrl_pkg::midi_cc_t    cc_held;
	synth_ctrl_pkg::touch_ev_t   touch_held;
	synth_ctrl_pkg::store_addr_t rd_held, store_rd_adr, init_addr;
	synth_ctrl_pkg::store_wr_t   map_wr, store_wr;
	logic                        use_touch, take, init_start, init_done, rd_en;
	logic                        pb_s1, pb_s2; // pitch strobe sync
	logic [6:0]                  pb_dat, pb_lsb;

	strobe_capture #(.payload_t(synth_ctrl_pkg::midi_cc_t)) u_cc_cap (
		.CLOCK_25, .ctrl_cmd_r, .strobe(cc_strobe), .payload(cc_in),
		.accept(cc_accept), .pending(cc_pending), .held(cc_held));

	strobe_capture #(.payload_t(synth_ctrl_pkg::touch_ev_t)) u_touch_cap (
		.CLOCK_25, .ctrl_cmd_r, .strobe(touch_strobe), .payload(touch_in),
		.accept(touch_accept), .pending(touch_pending), .held(touch_held));

	strobe_capture #(.payload_t(synth_ctrl_pkg::store_addr_t)) u_rd_cap (
		.CLOCK_25, .ctrl_cmd_r, .strobe(cpu_rd), .payload(cpu_adr),
		.accept(rd_accept), .pending(rd_pending), .held(rd_held));

	ctrl_map #(.V_OSC(V_OSC)) u_map (
		.CLOCK_25, .ctrl_cmd_r, .cc(cc_held), .touch(touch_held),
		.use_touch, .take, .edit_row, .wr(map_wr));

	init_counter #(.V_OSC(V_OSC)) u_init (
		.CLOCK_25, .ctrl_cmd_r, .start(init_start), .addr(init_addr), .done(init_done));

	write_sequencer #(.V_OSC(V_OSC)) u_seq (
		.CLOCK_25, .ctrl_cmd_r, .cc_pending, .touch_pending, .rd_pending,
		.init_addr, .init_done, .map_wr, .rd_adr(rd_held),
		.init_start, .cc_accept, .touch_accept, .rd_accept, .use_touch, .take,
		.wr(store_wr), .store_rd_adr, .rd_en, .busy);

	param_store #(.V_OSC(V_OSC)) u_store (
		.CLOCK_25, .ctrl_cmd_r, .wr(store_wr), .rd_en, .rd_adr(store_rd_adr),
		.rd_data(cpu_rd_data), .edit_row);

	// pitch bend, lsb on rising strobe, msb on falling
	always_ff @(posedge CLOCK_25 or posedge ctrl_cmd_r) begin
		if (ctrl_cmd_r) begin
			pb_s1     <= 1'b0;
			pb_s2     <= 1'b0;
			pitch_val <= synth_ctrl_pkg::PITCH_CENTER;
		end else begin
			pb_s1 <= pitch_strobe;
			pb_s2 <= pb_s1;
			if (!pb_s1 && pb_s2)
				pitch_val <= {pb_dat, pb_lsb}; // falling edge completes the pair
		end
	end

	always_ff @(posedge CLOCK_25) begin
		pb_dat <= pitch_in.data[6:0]; // sampled with the strobe sync
		if (pb_s1 && !pb_s2)
			pb_lsb <= pb_dat;
	end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

// bench clock and power-on reset
module tb_clock_gen (
	output logic CLOCK_25,
	output logic ctrl_cmd_r
);

	initial begin
		CLOCK_25 = 1'b0;
		forever #10 CLOCK_25 = ~CLOCK_25; // 20 ns period
	end

	initial begin
		ctrl_cmd_r = 1'b1;
		repeat (4) @(negedge CLOCK_25); // four rising edges in reset
		ctrl_cmd_r = 1'b0;
	end

endmodule

//--- bench/synth_ctrl_tb.sv
`timescale 1ns/1ps

module synth_ctrl_tb;

	localparam int V_OSC    = 4;
	localparam int O_WIDTH  = (V_OSC > 1) ? $clog2(V_OSC) : 1;
	localparam int SLOTS    = 4 * V_OSC + 2;
	localparam int DEPTH    = 16 * SLOTS;
	localparam int COM_SLOT = 4 * V_OSC;

	typedef enum logic [1:0] {K_CC, K_TOUCH, K_PITCH, K_READ} kind_t;

	typedef struct packed {
		kind_t       kind;
		logic [15:0] pay; // {num, data}, {idx, -}, {msb, lsb} or address
		logic [15:0] exp; // edit row, pitch value or read byte
	} step_t;

	logic                        CLOCK_25, ctrl_cmd_r;
	logic                        cc_strobe, touch_strobe, pitch_strobe, cpu_rd;
	synth_ctrl_pkg::midi_cc_t    cc_in, pitch_in;
	synth_ctrl_pkg::touch_ev_t   touch_in;
	synth_ctrl_pkg::store_addr_t cpu_adr;
	synth_ctrl_pkg::param_word_t cpu_rd_data;
	logic [O_WIDTH-1:0]          edit_row;
	logic [13:0]                 pitch_val;
	logic                        busy;

	step_t      steps[$];
	logic [7:0] model [DEPTH]; // expected store contents, slot*16 + column
	int         row_now;       // model edit row
	logic       half_sel;      // model column-half latch
	logic [31:0] lfsr;
	int         value_errs, other_errs;
	bit         timed_out;

	// all three touch ranges plus two unmapped indices
	logic [7:0] touch_idx [9] = '{8'd5, 8'd31, 8'd32, 8'd45, 8'd91, 8'd92, 8'd93, 8'd94, 8'd200};

	tb_clock_gen u_clk (.CLOCK_25, .ctrl_cmd_r);

	synth_ctrl_top #(.V_OSC(V_OSC)) u_dut (
		.CLOCK_25, .ctrl_cmd_r, .cc_strobe, .cc_in, .touch_strobe, .touch_in,
		.pitch_strobe, .pitch_in, .cpu_rd, .cpu_adr, .cpu_rd_data, .edit_row,
		.pitch_val, .busy);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] next_random_byte();
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// power-up byte per slot and column
	function automatic logic [7:0] reset_byte(input int slot, input int col);
		logic [7:0] b;
		b = 8'h00;
		if (slot < V_OSC && col == 6)
			b = 8'h7f;
		else if (slot >= V_OSC && slot < 2 * V_OSC && col inside {0, 1, 8, 9})
			b = 8'h40;
		else if (slot >= V_OSC && slot < 2 * V_OSC && col == 2)
			b = 8'h7f;
		else if (slot == COM_SLOT && col == 0)
			b = 8'h02;
		else if (slot == COM_SLOT && col == 1)
			b = 8'd60;
		return b;
	endfunction

	task automatic add_step(input kind_t k, input logic [15:0] p, input logic [15:0] e);
		step_t st;
		st.kind = k;
		st.pay  = p;
		st.exp  = e;
		steps.push_back(st);
	endtask

	// cc rule on the model, addr is -1 when nothing is written
	task automatic model_cc(input logic [7:0] num, input logic [7:0] data, output int addr);
		int         n;
		int         slot;
		int         col;
		logic [7:0] val;
		n    = int'(num);
		slot = -1;
		col  = 0;
		val  = data;
		if (n >= 22 && n <= 29) begin // upper buttons
			half_sel = data[0];
			slot     = COM_SLOT + 1;
			col      = 6;
			val      = 8'(n - 22);
		end else if (n == 39) begin
			slot = COM_SLOT;
			col  = 1;
		end else if (n >= 48 && n <= 55) begin // faders
			slot = row_now;
			col  = n - 48 + 8 * int'(half_sel);
		end else if (n >= 56 && n <= 63) begin
			slot    = COM_SLOT;
			col     = 4;
			val     = 8'(n - 56);
			row_now = (n - 56) % V_OSC; // low bits become the edit row
		end else if (n >= 76 && n <= 83) begin // knobs
			slot = V_OSC + row_now;
			col  = n - 76 + 8 * int'(half_sel);
		end
		addr = (slot < 0) ? -1 : slot * 16 + col;
		if (addr >= 0)
			model[addr] = val;
	endtask

	task automatic model_touch(input logic [7:0] idx, input logic [7:0] val, output int addr);
		int slot;
		int col;
		slot = -1;
		col  = 0;
		if (idx < 8'd32) begin // envelope sliders
			slot = int'(idx[4:3]);
			col  = int'({idx[0], idx[2], idx[1]});
		end else if (idx < 8'd92) begin
			slot = V_OSC + int'({idx[6], idx[4]});
			col  = int'(idx[3:0]); // bit 3 is the half
		end else if (idx < 8'd94) begin
			slot = COM_SLOT;
			col  = int'(idx) - 92;
		end
		addr = (slot < 0) ? -1 : slot * 16 + col;
		if (addr >= 0)
			model[addr] = val;
	endtask

	task automatic compare_byte(input string name, input synth_ctrl_pkg::param_word_t exp,
		input synth_ctrl_pkg::param_word_t act);
		if (act !== exp) begin
			value_errs++;
			$display("[FAIL] t=%0t %s expected %02h got %02h", $time, name, exp, act);
		end
	endtask

	task automatic compare_row(input logic [O_WIDTH-1:0] exp, input logic [O_WIDTH-1:0] act);
		if (act !== exp) begin
			value_errs++;
			$display("[FAIL] t=%0t edit_row expected %0d got %0d", $time, exp, act);
		end
	endtask

	task automatic compare_pitch(input logic [13:0] exp, input logic [13:0] act);
		if (act !== exp) begin
			value_errs++;
			$display("[FAIL] t=%0t pitch_val expected %0d got %0d", $time, exp, act);
		end
	endtask

	// strobe high for 3 cycles, then 8 idle cycles, all on falling edges
	task automatic fire_strobe(input kind_t k, input logic [15:0] pay);
		@(negedge CLOCK_25);
		case (k)
			K_CC: begin
				cc_in     = pay;
				cc_strobe = 1'b1;
			end
			K_TOUCH: begin
				touch_in     = pay;
				touch_strobe = 1'b1;
			end
			K_PITCH: begin
				pitch_in.data = pay[7:0]; // lsb goes with the rising edge
				pitch_strobe  = 1'b1;
			end
			default: begin
				cpu_adr = pay[8:0];
				cpu_rd  = 1'b1;
			end
		endcase
		repeat (3) @(negedge CLOCK_25);
		cc_strobe    = 1'b0;
		touch_strobe = 1'b0;
		cpu_rd       = 1'b0;
		if (k == K_PITCH) begin
			pitch_strobe  = 1'b0;
			pitch_in.data = pay[15:8]; // msb with the falling edge
		end
		for (int i = 0; i < 8; i++)
			@(negedge CLOCK_25);
	endtask

	task automatic read_back(input int addr);
		fire_strobe(K_READ, 16'(addr));
		compare_byte($sformatf("cpu_rd_data[%03h]", addr), model[addr], cpu_rd_data);
	endtask

	task automatic wait_reset_release();
		for (int n = 0; n < 20 && ctrl_cmd_r !== 1'b0; n++)
			@(negedge CLOCK_25);
		if (ctrl_cmd_r !== 1'b0) begin
			timed_out = 1'b1;
			other_errs++;
			$display("reset was never released");
		end
	endtask

	task automatic wait_busy_low();
		for (int n = 0; n < DEPTH + 64 && busy !== 1'b0; n++)
			@(negedge CLOCK_25);
		if (busy !== 1'b0) begin
			timed_out = 1'b1;
			other_errs++;
			$display("busy stayed high, store init never finished");
		end
	endtask

	task automatic build_table();
		// defaults after reset
		add_step(K_READ, 16'h006, 16'h7f);
		add_step(K_READ, 16'h048, 16'h40);
		add_step(K_READ, 16'h052, 16'h7f);
		add_step(K_READ, 16'h100, 16'h02);
		add_step(K_READ, 16'h101, 16'd60);
		add_step(K_READ, 16'h113, 16'h00);
		add_step(K_READ, 16'h0f0, 16'h00);
		add_step(K_CC, {8'd58, 8'h7f}, 16'd2); // edit row 2
		add_step(K_CC, {8'd50, 8'h55}, 16'd2);
		add_step(K_CC, {8'd23, 8'h01}, 16'd2); // upper half on
		add_step(K_CC, {8'd78, 8'h33}, 16'd2);
		add_step(K_CC, {8'd22, 8'h02}, 16'd2); // back to lower half
		add_step(K_CC, {8'd79, 8'h44}, 16'd2);
		add_step(K_CC, {8'd39, 8'h70}, 16'd2);
		add_step(K_CC, {8'd63, 8'h00}, 16'd3);
		add_step(K_CC, {8'd55, 8'h11}, 16'd3);
		add_step(K_CC, {8'd57, 8'h00}, 16'd1);
		add_step(K_CC, {8'd83, 8'h22}, 16'd1);
		foreach (touch_idx[i])
			add_step(K_TOUCH, {touch_idx[i], 8'h00}, 16'd1);
		add_step(K_CC, {8'd30, 8'h5a}, 16'd1); // unmapped numbers
		add_step(K_CC, {8'd40, 8'h5a}, 16'd1);
		add_step(K_CC, {8'd64, 8'h5a}, 16'd1);
		add_step(K_CC, {8'd100, 8'h5a}, 16'd1);
		add_step(K_PITCH, {8'h25, 8'h6b}, {2'b00, 7'h25, 7'h6b});
		add_step(K_PITCH, {8'hff, 8'h80}, {2'b00, 7'h7f, 7'h00});
	endtask

	initial begin
		int         addr;
		step_t      st;
		logic [7:0] rnd;
		cc_strobe    = 1'b0;
		touch_strobe = 1'b0;
		pitch_strobe = 1'b0;
		cpu_rd       = 1'b0;
		cc_in        = '0;
		touch_in     = '0;
		pitch_in     = {8'he0, 8'h00}; // bend status byte
		cpu_adr      = '0;
		lfsr         = 32'h5fa7;
		row_now      = 0;
		half_sel     = 1'b0;
		value_errs   = 0;
		other_errs   = 0;
		timed_out    = 1'b0;
		for (int a = 0; a < DEPTH; a++)
			model[a] = reset_byte(a / 16, a % 16);
		build_table();
		wait_reset_release();
		if (!timed_out && busy !== 1'b1) begin
			other_errs++;
			$display("busy was not high right after reset");
		end
		if (!timed_out)
			wait_busy_low();
		if (!timed_out) begin
			compare_pitch(14'd8191, pitch_val);
			compare_byte("cpu_rd_data", 8'h00, cpu_rd_data);
			compare_row('0, edit_row);
		end
		for (int i = 0; i < steps.size() && !timed_out; i++) begin
			st = steps[i];
			case (st.kind)
				K_CC: begin
					model_cc(st.pay[15:8], st.pay[7:0], addr);
					fire_strobe(K_CC, st.pay);
					compare_row(st.exp[O_WIDTH-1:0], edit_row);
					if (addr >= 0)
						read_back(addr);
				end
				K_TOUCH: begin
					rnd = next_random_byte();
					model_touch(st.pay[15:8], rnd, addr);
					fire_strobe(K_TOUCH, {st.pay[15:8], rnd});
					compare_row(st.exp[O_WIDTH-1:0], edit_row);
					if (addr >= 0)
						read_back(addr);
				end
				K_PITCH: begin
					fire_strobe(K_PITCH, st.pay);
					compare_pitch(st.exp[13:0], pitch_val);
				end
				default: begin
					fire_strobe(K_READ, st.pay);
					compare_byte($sformatf("cpu_rd_data[%03h]", st.pay[8:0]), st.exp[7:0],
						cpu_rd_data);
				end
			endcase
		end
		// full sweep, unmapped events must leave everything else alone
		for (int a = 0; a < DEPTH && !timed_out; a++)
			read_back(a);
		$display("errors: %0d (value mismatches %0d, other failures %0d)",
			value_errs + other_errs, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- src.f
design/synth_ctrl_pkg.sv
design/strobe_capture.sv
design/ctrl_map.sv
design/init_counter.sv
design/write_sequencer.sv
design/param_store.sv
design/synth_ctrl_top.sv
bench/tb_clock_gen.sv
bench/synth_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile with verilator, run, then scan the log
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module synth_ctrl_tb -f src.f -o synth_ctrl_sim \
	&& ./obj_dir/synth_ctrl_sim 2>&1 | tee sim.log \
	&& ! grep -q "Test failed" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }
